//--- Bender.yml
package:
  name: wbx_crossbar

sources:
  - source/wbx_pkg.sv
  - source/wbx_req_if.sv
  - source/wbx_request_router.sv
  - source/wbx_grant_fsm.sv
  - source/wbx_pending_timer.sv
  - source/wbx_slave_port.sv
  - source/wbx_top.sv
  - target: test
    files:
      - tb/tb_wb_slave_model.sv
      - tb/tb_wbx_top.sv

//--- files.f
source/wbx_pkg.sv
source/wbx_req_if.sv
source/wbx_request_router.sv
source/wbx_grant_fsm.sv
source/wbx_pending_timer.sv
source/wbx_slave_port.sv
source/wbx_top.sv
tb/tb_wb_slave_model.sv
tb/tb_wbx_top.sv

//--- source/wbx_grant_fsm.sv
//////////////////////////////////////////////////
// per-master grant FSM, builds master stall and
// muxes ack, err and read data from the held slave
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module wbx_grant_fsm (
	input  wire                              i_clk,
	input  wire                              i_rst_n,
	input  wire                              i_cyc,
	input  wire                              i_stb,
	input  wire wbx_pkg::slave_idx_t         i_target,
	input  wire                              i_available,
	input  wire                              i_full,
	input  wire                              i_empty,
	input  wire                              i_timed_out,
	input  wire [wbx_pkg::NUM_SLAVES-1:0]    i_sstall,
	input  wire [wbx_pkg::NUM_SLAVES-1:0]    i_sack,
	input  wire [wbx_pkg::NUM_SLAVES-1:0]    i_serr,
	input  wire wbx_pkg::data_t              i_sdata [wbx_pkg::NUM_SLAVES],
	output logic                             o_granted,
	output wbx_pkg::slave_idx_t              o_slave,
	output logic                             o_mstall,
	output logic                             o_mack,
	output logic                             o_merr,
	output wbx_pkg::data_t                   o_mdata
);

	wbx_pkg::grant_state_e r_state;
	wbx_pkg::grant_state_e next_state;
	wbx_pkg::slave_idx_t   r_slave;

	// return signals of the held slave
	logic            sel_stall;
	logic            sel_ack;
	logic            sel_err;
	wbx_pkg::data_t  sel_data;
	logic            in_grant;

	assign in_grant = (r_state == wbx_pkg::GRANTED);

	// return path mux, idle values when no slave held
	always_comb
	begin
		sel_stall = 1'b1;
		sel_ack   = 1'b0;
		sel_err   = 1'b0;
		sel_data  = '0;
		for (int s = 0; s < wbx_pkg::NUM_SLAVES; s++)
		begin
			if (r_slave == wbx_pkg::slave_idx_t'(s))
			begin
				sel_stall = i_sstall[s];
				sel_ack   = i_sack[s];
				sel_err   = i_serr[s];
				sel_data  = i_sdata[s];
			end
		end
	end

	//////////////////////////////////////////////////
	// state machine
	//////////////////////////////////////////////////

	always_comb
	begin
		next_state = r_state;
		case (r_state)
			wbx_pkg::IDLE:
			begin
				// unmapped address errors out, mapped one waits for its slave
				if (i_cyc && i_stb && (i_target == wbx_pkg::NO_SLAVE))
					next_state = wbx_pkg::ERROR;
				else if (i_cyc && i_stb && i_available)
					next_state = wbx_pkg::GRANTED;
			end
			wbx_pkg::GRANTED:
			begin
				// slave err releases the slave, watchdog gives own err
				if (!i_cyc || sel_err)
					next_state = wbx_pkg::IDLE;
				else if (i_timed_out)
					next_state = wbx_pkg::ERROR;
			end
			// error lasts a single cycle
			default:
				next_state = wbx_pkg::IDLE;
		endcase
	end

	always_ff @(posedge i_clk)
	begin
		if (!i_rst_n)
		begin
			r_state <= wbx_pkg::IDLE;
			r_slave <= wbx_pkg::NO_SLAVE;
		end
		else
		begin
			r_state <= next_state;
			// latch the slave index on the way into GRANTED
			if ((r_state == wbx_pkg::IDLE) && (next_state == wbx_pkg::GRANTED))
				r_slave <= i_target;
		end
	end

	//////////////////////////////////////////////////
	// master side outputs
	//////////////////////////////////////////////////

	// the slave port only issues while this is high, so a full
	// counter pauses issue without giving up the slave
	assign o_granted = in_grant && !i_full;
	assign o_slave   = r_slave;

	// stalled when not granted, aimed elsewhere, slave stalls or full
	assign o_mstall = !in_grant || (i_target != r_slave) || sel_stall || i_full;

	// an ack with nothing pending is dropped
	assign o_mack  = in_grant && sel_ack && !i_empty;
	assign o_merr  = (in_grant && sel_err) || (r_state == wbx_pkg::ERROR);
	assign o_mdata = in_grant ? sel_data : '0;

endmodule

`default_nettype wire

//--- source/wbx_pending_timer.sv
//////////////////////////////////////////////////
// counts one master's outstanding requests and runs
// the ack watchdog that ends a stuck bus cycle
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module wbx_pending_timer (
	input  wire   i_clk,
	input  wire   i_rst_n,
	input  wire   i_cyc,
	input  wire   i_accept,
	input  wire   i_ack,
	input  wire   i_err,
	output logic  o_full,
	output logic  o_empty,
	output logic  o_timed_out
);

	wbx_pkg::pending_t r_count;
	wbx_pkg::timer_t   r_timer;

	//////////////////////////////////////////////////
	// outstanding request count
	//////////////////////////////////////////////////

	// accept and ack together leave the count unchanged
	always_ff @(posedge i_clk)
	begin
		if (!i_rst_n || !i_cyc || i_err)
			r_count <= '0;
		else if (i_accept && !i_ack)
			r_count <= r_count + 1'b1;
		else if (!i_accept && i_ack)
			r_count <= r_count - 1'b1;
	end

	assign o_full  = &r_count;
	assign o_empty = (r_count == '0);

	//////////////////////////////////////////////////
	// ack watchdog
	//////////////////////////////////////////////////

	// any bus progress or an idle count restarts the countdown
	always_ff @(posedge i_clk)
	begin
		if (!i_rst_n || !i_cyc || i_err || i_accept || i_ack || o_empty)
			r_timer <= wbx_pkg::timer_t'(wbx_pkg::TIMEOUT_CYCLES);
		else if (r_timer != '0)
			r_timer <= r_timer - 1'b1;
	end

	// expired with requests still waiting
	assign o_timed_out = !o_empty && (r_timer == '0);

endmodule

`default_nettype wire

//--- source/wbx_pkg.sv
//////////////////////////////////////////////////
// sizes, slave address map and shared types of the
// two-master, two-slave Wishbone crossbar; every
// design file refers to these by scoped name
//////////////////////////////////////////////////
`default_nettype none

package wbx_pkg;

	// port counts and bus widths
	localparam int NUM_MASTERS    = 2;
	localparam int NUM_SLAVES     = 2;
	localparam int ADDR_W         = 20;
	localparam int DATA_W         = 32;
	localparam int SEL_W          = 4;

	// pending counter is full at all ones, 15 requests
	localparam int PENDING_W      = 4;
	localparam int TIMEOUT_CYCLES = 31;
	localparam int TIMER_W        = $clog2(TIMEOUT_CYCLES + 1);

	typedef logic [ADDR_W-1:0]    addr_t;
	typedef logic [DATA_W-1:0]    data_t;
	typedef logic [SEL_W-1:0]     sel_t;
	typedef logic [PENDING_W-1:0] pending_t;
	typedef logic [TIMER_W-1:0]   timer_t;

	// one bit wider than needed so that NUM_SLAVES can mean no slave
	typedef logic [1:0] slave_idx_t;
	typedef logic [0:0] master_idx_t;

	localparam slave_idx_t NO_SLAVE = slave_idx_t'(NUM_SLAVES);

	// slave 0 at top nibble 0, slave 1 at top nibble 1
	localparam addr_t SLAVE_BASE [NUM_SLAVES] = '{20'h0_0000, 20'h1_0000};
	localparam addr_t SLAVE_MASK [NUM_SLAVES] = '{20'hf_0000, 20'hf_0000};

	typedef enum logic [1:0] {IDLE, GRANTED, ERROR} grant_state_e;

	// address to slave index, NO_SLAVE when unmapped
	function automatic slave_idx_t decode(input addr_t addr);
		slave_idx_t idx;
		idx = NO_SLAVE;
		for (int s = 0; s < NUM_SLAVES; s++)
		begin
			if (((addr ^ SLAVE_BASE[s]) & SLAVE_MASK[s]) == '0)
				idx = slave_idx_t'(s);
		end
		return idx;
	endfunction

endpackage

`default_nettype wire

//--- source/wbx_req_if.sv
//////////////////////////////////////////////////
// one master's Wishbone request bundle, driven at
// the top level and read by router and slave ports
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

interface wbx_req_if;

	// cycle framing and strobe
	logic            cyc;
	logic            stb;
	logic            we;

	// payload of the request
	wbx_pkg::addr_t  addr;
	wbx_pkg::data_t  data;
	wbx_pkg::sel_t   sel;

	modport master (output cyc, stb, we, addr, data, sel);
	modport slave  (input  cyc, stb, we, addr, data, sel);

endinterface

`default_nettype wire

//--- source/wbx_request_router.sv
//////////////////////////////////////////////////
// decodes each master's address and tells its grant
// FSM whether the target slave can be taken now
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module wbx_request_router (
	wbx_req_if.slave                           i_req [wbx_pkg::NUM_MASTERS],
	input  wire [wbx_pkg::NUM_SLAVES-1:0]      i_slave_busy,
	output wbx_pkg::slave_idx_t                o_target [wbx_pkg::NUM_MASTERS],
	output logic [wbx_pkg::NUM_MASTERS-1:0]    o_available
);

	// master has a live strobe this cycle
	logic [wbx_pkg::NUM_MASTERS-1:0] req;
	// target slave already held by someone
	logic [wbx_pkg::NUM_MASTERS-1:0] target_busy;
	// lower numbered master wants the same slave
	logic [wbx_pkg::NUM_MASTERS-1:0] blocked;

	//////////////////////////////////////////////////
	// address decode
	//////////////////////////////////////////////////

	// interface arrays need constant indices, hence the generate
	for (genvar m = 0; m < wbx_pkg::NUM_MASTERS; m++)
	begin : g_decode
		assign req[m]      = i_req[m].cyc && i_req[m].stb;
		assign o_target[m] = wbx_pkg::decode(i_req[m].addr);
	end

	//////////////////////////////////////////////////
	// fixed priority, master 0 first
	//////////////////////////////////////////////////

	always_comb
	begin
		for (int m = 0; m < wbx_pkg::NUM_MASTERS; m++)
		begin
			// look up busy of the target, unmapped stays not busy
			target_busy[m] = 1'b0;
			for (int s = 0; s < wbx_pkg::NUM_SLAVES; s++)
			begin
				if (o_target[m] == wbx_pkg::slave_idx_t'(s))
					target_busy[m] = i_slave_busy[s];
			end

			// any lower master requesting the same slave wins
			blocked[m] = 1'b0;
			for (int l = 0; l < m; l++)
			begin
				if (req[l] && (o_target[l] == o_target[m]))
					blocked[m] = 1'b1;
			end

			o_available[m] = (o_target[m] != wbx_pkg::NO_SLAVE)
				&& !target_busy[m] && !blocked[m];
		end
	end

endmodule

`default_nettype wire

//--- source/wbx_slave_port.sv
//////////////////////////////////////////////////
// one slave port: finds the owning master and
// registers its request onto the slave bus
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module wbx_slave_port #(
	parameter int SLAVE_IDX = 0
) (
	input  wire                               i_clk,
	input  wire                               i_rst_n,
	wbx_req_if.slave                          i_req [wbx_pkg::NUM_MASTERS],
	input  wire [wbx_pkg::NUM_MASTERS-1:0]    i_granted,
	input  wire wbx_pkg::slave_idx_t          i_slave [wbx_pkg::NUM_MASTERS],
	input  wire                               i_sstall,
	input  wire                               i_serr,
	output logic                              o_busy,
	output logic                              o_scyc,
	output logic                              o_sstb,
	output logic                              o_swe,
	output wbx_pkg::addr_t                    o_saddr,
	output wbx_pkg::data_t                    o_sdata,
	output wbx_pkg::sel_t                     o_ssel
);

	// flat copies of the request interfaces
	logic [wbx_pkg::NUM_MASTERS-1:0] m_cyc;
	logic [wbx_pkg::NUM_MASTERS-1:0] m_stb;
	logic [wbx_pkg::NUM_MASTERS-1:0] m_we;
	wbx_pkg::addr_t                  m_addr [wbx_pkg::NUM_MASTERS];
	wbx_pkg::data_t                  m_data [wbx_pkg::NUM_MASTERS];
	wbx_pkg::sel_t                   m_sel  [wbx_pkg::NUM_MASTERS];

	logic [wbx_pkg::NUM_MASTERS-1:0] claim;
	logic                            any_claim;
	wbx_pkg::master_idx_t            owner;
	wbx_pkg::master_idx_t            r_owner;
	logic                            hit;
	logic                            keep;

	for (genvar m = 0; m < wbx_pkg::NUM_MASTERS; m++)
	begin : g_copy
		assign m_cyc[m]  = i_req[m].cyc;
		assign m_stb[m]  = i_req[m].stb;
		assign m_we[m]   = i_req[m].we;
		assign m_addr[m] = i_req[m].addr;
		assign m_data[m] = i_req[m].data;
		assign m_sel[m]  = i_req[m].sel;
	end

	//////////////////////////////////////////////////
	// owner select
	//////////////////////////////////////////////////

	// at most one master can claim, the router makes sure of that
	always_comb
	begin
		owner = r_owner;
		for (int m = 0; m < wbx_pkg::NUM_MASTERS; m++)
		begin
			claim[m] = i_granted[m]
				&& (i_slave[m] == wbx_pkg::slave_idx_t'(SLAVE_IDX));
			if (claim[m])
				owner = wbx_pkg::master_idx_t'(m);
		end
	end

	assign any_claim = |claim;
	// owner still aims at this slave
	assign hit  = (wbx_pkg::decode(m_addr[owner]) == wbx_pkg::slave_idx_t'(SLAVE_IDX));
	assign keep = (any_claim || o_scyc) && m_cyc[owner];
	// scyc keeps the slave taken while the owner is paused on a full count
	assign o_busy = any_claim || o_scyc;

	always_ff @(posedge i_clk)
	begin
		if (!i_rst_n)
			r_owner <= '0;
		else if (any_claim)
			r_owner <= owner;
	end

	//////////////////////////////////////////////////
	// registered slave request
	//////////////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (!i_rst_n || i_serr || !keep)
		begin
			o_scyc <= 1'b0;
			o_sstb <= 1'b0;
		end
		else
		begin
			o_scyc <= 1'b1;
			// stb holds while the slave stalls
			if (!i_sstall)
				o_sstb <= any_claim && m_stb[owner] && hit;
		end
	end

	// payload follows the owner whenever the slave takes a beat
	always_ff @(posedge i_clk)
	begin
		if (!i_sstall)
		begin
			o_swe   <= m_we[owner];
			o_saddr <= m_addr[owner];
			o_sdata <= m_data[owner];
			o_ssel  <= m_sel[owner];
		end
	end

endmodule

`default_nettype wire

//--- source/wbx_top.sv
//////////////////////////////////////////////////
// crossbar top with flat packed master and slave
// ports, wiring FSMs, timers, router and slave ports
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module wbx_top (
	input  wire                                                i_clk,
	input  wire                                                i_rst_n,
	// master side
	input  wire [wbx_pkg::NUM_MASTERS-1:0]                     i_mcyc,
	input  wire [wbx_pkg::NUM_MASTERS-1:0]                     i_mstb,
	input  wire [wbx_pkg::NUM_MASTERS-1:0]                     i_mwe,
	input  wire [wbx_pkg::NUM_MASTERS*wbx_pkg::ADDR_W-1:0]     i_maddr,
	input  wire [wbx_pkg::NUM_MASTERS*wbx_pkg::DATA_W-1:0]     i_mdata,
	input  wire [wbx_pkg::NUM_MASTERS*wbx_pkg::SEL_W-1:0]      i_msel,
	output wire [wbx_pkg::NUM_MASTERS-1:0]                     o_mstall,
	output wire [wbx_pkg::NUM_MASTERS-1:0]                     o_mack,
	output wire [wbx_pkg::NUM_MASTERS-1:0]                     o_merr,
	output wire [wbx_pkg::NUM_MASTERS*wbx_pkg::DATA_W-1:0]     o_mdata,
	// slave side
	output wire [wbx_pkg::NUM_SLAVES-1:0]                      o_scyc,
	output wire [wbx_pkg::NUM_SLAVES-1:0]                      o_sstb,
	output wire [wbx_pkg::NUM_SLAVES-1:0]                      o_swe,
	output wire [wbx_pkg::NUM_SLAVES*wbx_pkg::ADDR_W-1:0]      o_saddr,
	output wire [wbx_pkg::NUM_SLAVES*wbx_pkg::DATA_W-1:0]      o_sdata,
	output wire [wbx_pkg::NUM_SLAVES*wbx_pkg::SEL_W-1:0]       o_ssel,
	input  wire [wbx_pkg::NUM_SLAVES-1:0]                      i_sstall,
	input  wire [wbx_pkg::NUM_SLAVES-1:0]                      i_sack,
	input  wire [wbx_pkg::NUM_SLAVES-1:0]                      i_serr,
	input  wire [wbx_pkg::NUM_SLAVES*wbx_pkg::DATA_W-1:0]      i_sdata
);

	wire wbx_pkg::slave_idx_t              target    [wbx_pkg::NUM_MASTERS];
	wire [wbx_pkg::NUM_MASTERS-1:0]        available;
	wire [wbx_pkg::NUM_MASTERS-1:0]        granted;
	wire wbx_pkg::slave_idx_t              gslave    [wbx_pkg::NUM_MASTERS];
	wire [wbx_pkg::NUM_MASTERS-1:0]        accept;
	wire [wbx_pkg::NUM_MASTERS-1:0]        full;
	wire [wbx_pkg::NUM_MASTERS-1:0]        empty;
	wire [wbx_pkg::NUM_MASTERS-1:0]        timed_out;
	wire [wbx_pkg::NUM_SLAVES-1:0]         slave_busy;
	wire wbx_pkg::data_t                   sdata     [wbx_pkg::NUM_SLAVES];

	wbx_req_if u_req [wbx_pkg::NUM_MASTERS] ();

	//////////////////////////////////////////////////
	// master side, one FSM and one timer per master
	//////////////////////////////////////////////////

	for (genvar m = 0; m < wbx_pkg::NUM_MASTERS; m++)
	begin : g_master
		assign u_req[m].cyc  = i_mcyc[m];
		assign u_req[m].stb  = i_mstb[m];
		assign u_req[m].we   = i_mwe[m];
		assign u_req[m].addr = i_maddr[m*wbx_pkg::ADDR_W +: wbx_pkg::ADDR_W];
		assign u_req[m].data = i_mdata[m*wbx_pkg::DATA_W +: wbx_pkg::DATA_W];
		assign u_req[m].sel  = i_msel[m*wbx_pkg::SEL_W +: wbx_pkg::SEL_W];

		// Wishbone accept, strobe seen while not stalled
		assign accept[m] = i_mstb[m] && !o_mstall[m];

		wbx_grant_fsm u_fsm (
			.i_clk       (i_clk),
			.i_rst_n     (i_rst_n),
			.i_cyc       (i_mcyc[m]),
			.i_stb       (i_mstb[m]),
			.i_target    (target[m]),
			.i_available (available[m]),
			.i_full      (full[m]),
			.i_empty     (empty[m]),
			.i_timed_out (timed_out[m]),
			.i_sstall    (i_sstall),
			.i_sack      (i_sack),
			.i_serr      (i_serr),
			.i_sdata     (sdata),
			.o_granted   (granted[m]),
			.o_slave     (gslave[m]),
			.o_mstall    (o_mstall[m]),
			.o_mack      (o_mack[m]),
			.o_merr      (o_merr[m]),
			.o_mdata     (o_mdata[m*wbx_pkg::DATA_W +: wbx_pkg::DATA_W])
		);

		wbx_pending_timer u_timer (
			.i_clk       (i_clk),
			.i_rst_n     (i_rst_n),
			.i_cyc       (i_mcyc[m]),
			.i_accept    (accept[m]),
			.i_ack       (o_mack[m]),
			.i_err       (o_merr[m]),
			.o_full      (full[m]),
			.o_empty     (empty[m]),
			.o_timed_out (timed_out[m])
		);
	end

	wbx_request_router u_router (
		.i_req        (u_req),
		.i_slave_busy (slave_busy),
		.o_target     (target),
		.o_available  (available)
	);

	//////////////////////////////////////////////////
	// slave side, one registered port per slave
	//////////////////////////////////////////////////

	for (genvar s = 0; s < wbx_pkg::NUM_SLAVES; s++)
	begin : g_slave
		assign sdata[s] = i_sdata[s*wbx_pkg::DATA_W +: wbx_pkg::DATA_W];

		wbx_slave_port #(
			.SLAVE_IDX (s)
		) u_port (
			.i_clk     (i_clk),
			.i_rst_n   (i_rst_n),
			.i_req     (u_req),
			.i_granted (granted),
			.i_slave   (gslave),
			.i_sstall  (i_sstall[s]),
			.i_serr    (i_serr[s]),
			.o_busy    (slave_busy[s]),
			.o_scyc    (o_scyc[s]),
			.o_sstb    (o_sstb[s]),
			.o_swe     (o_swe[s]),
			.o_saddr   (o_saddr[s*wbx_pkg::ADDR_W +: wbx_pkg::ADDR_W]),
			.o_sdata   (o_sdata[s*wbx_pkg::DATA_W +: wbx_pkg::DATA_W]),
			.o_ssel    (o_ssel[s*wbx_pkg::SEL_W +: wbx_pkg::SEL_W])
		);
	end

endmodule

`default_nettype wire

//--- tb/tb_wb_slave_model.sv
//////////////////////////////////////////////////
// behavioral Wishbone memory slave for the crossbar
// testbench, one ack per beat, random stall, mute mode
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module tb_wb_slave_model #(
	parameter int          IDX  = 0,
	parameter logic [31:0] SEED = 32'h1
) (
	input  wire         i_clk,
	input  wire         i_rst_n,
	input  wire         i_cyc,
	input  wire         i_stb,
	input  wire         i_we,
	input  wire [19:0]  i_addr,
	input  wire [31:0]  i_data,
	input  wire [3:0]   i_sel,
	input  wire         i_stall_en,
	input  wire         i_mute,
	output logic        o_stall,
	output logic        o_ack,
	output wire         o_err,
	output logic [31:0] o_data
);

	// 64 KiB window per slave, word addressed
	logic [31:0] mem [16384];
	logic [31:0] lcg_state;
	logic [31:0] rnd;
	wire  [13:0] widx;

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	assign widx  = i_addr[15:2];
	assign o_err = 1'b0;

	// fill pattern carries the word index and the slave number
	initial
	begin
		lcg_state = SEED;
		for (int w = 0; w < 16384; w++)
			mem[w] = {w[13:0], 4'(IDX), w[13:0]};
	end

	always @(posedge i_clk)
	begin
		if (!i_rst_n)
		begin
			o_stall <= 1'b0;
			o_ack   <= 1'b0;
			o_data  <= '0;
		end
		else
		begin
			o_ack <= 1'b0;
			// a muted slave swallows the beat and never answers
			if (i_cyc && i_stb && !o_stall && !i_mute)
			begin
				o_ack <= 1'b1;
				if (i_we)
				begin
					for (int b = 0; b < 4; b++)
						if (i_sel[b])
							mem[widx][b*8 +: 8] <= i_data[b*8 +: 8];
				end
				else
					o_data <= mem[widx];
			end
			rnd = lcg_next();
			o_stall <= i_stall_en && rnd[16];
		end
	end

endmodule

`default_nettype wire

//--- tb/tb_wbx_top.sv
//////////////////////////////////////////////////
// crossbar testbench with two pipelined master
// drivers, two memory slaves, assertions and report
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module tb_wbx_top;

	localparam int BURST     = 8;
	// generous cycle budget of one burst including stalls
	localparam int BURST_CYC = BURST * 6 + 12;
	localparam int RUN_CYC   = 20 + 18 * BURST_CYC + 24 + wbx_pkg::TIMEOUT_CYCLES + 12;

	logic        i_clk = 1'b0;
	logic        i_rst_n;
	logic [1:0]  mcyc;
	logic [1:0]  mstb;
	logic [1:0]  mwe;
	logic [39:0] maddr;
	logic [63:0] mdata;
	logic [7:0]  msel;
	logic [1:0]  stall_en;
	logic [1:0]  mute;

	wire  [1:0]  o_mstall;
	wire  [1:0]  o_mack;
	wire  [1:0]  o_merr;
	wire  [63:0] o_mdata;
	wire  [1:0]  o_scyc;
	wire  [1:0]  o_sstb;
	wire  [1:0]  o_swe;
	wire  [39:0] o_saddr;
	wire  [63:0] o_sdata;
	wire  [7:0]  o_ssel;
	wire  [1:0]  sstall;
	wire  [1:0]  sack;
	wire  [1:0]  serr;
	wire  [63:0] sdata;

	// request lists per master filled before each burst
	logic [19:0] q_addr  [2][BURST];
	logic [31:0] q_data  [2][BURST];
	logic [3:0]  q_sel   [2][BURST];
	logic        q_we    [2];
	logic [31:0] rd_data [2][BURST];
	int          n_acc [2];
	int          n_ack [2];
	int          n_err [2];
	int          t_acc [2];
	int          t_err [2];

	// expected memory contents keyed by word address with byte valid flags
	logic [31:0] ref_mem [logic [19:0]];
	logic [3:0]  ref_val [logic [19:0]];

	logic [31:0] lcg_state = 32'haca8d678;
	int          errors = 0;
	int          err_mark = 0;
	int          tests = 0;

	always #2 i_clk = ~i_clk;

	wbx_top i_dut (
		.i_clk (i_clk), .i_rst_n (i_rst_n),
		.i_mcyc (mcyc), .i_mstb (mstb), .i_mwe (mwe),
		.i_maddr (maddr), .i_mdata (mdata), .i_msel (msel),
		.o_mstall (o_mstall), .o_mack (o_mack), .o_merr (o_merr), .o_mdata (o_mdata),
		.o_scyc (o_scyc), .o_sstb (o_sstb), .o_swe (o_swe),
		.o_saddr (o_saddr), .o_sdata (o_sdata), .o_ssel (o_ssel),
		.i_sstall (sstall), .i_sack (sack), .i_serr (serr), .i_sdata (sdata)
	);

	for (genvar s = 0; s < 2; s++)
	begin : g_slave
		tb_wb_slave_model #(.IDX (s), .SEED (32'haca8d678 ^ (s + 1))) u_mem (
			.i_clk (i_clk), .i_rst_n (i_rst_n),
			.i_cyc (o_scyc[s]), .i_stb (o_sstb[s]), .i_we (o_swe[s]),
			.i_addr (o_saddr[s*20 +: 20]), .i_data (o_sdata[s*32 +: 32]),
			.i_sel (o_ssel[s*4 +: 4]),
			.i_stall_en (stall_en[s]), .i_mute (mute[s]),
			.o_stall (sstall[s]), .o_ack (sack[s]), .o_err (serr[s]),
			.o_data (sdata[s*32 +: 32])
		);

		// a stalled beat keeps its strobe and payload
		hold_beat: assert property (@(posedge i_clk) disable iff (!i_rst_n)
			o_sstb[s] && sstall[s] |=> o_sstb[s] && $stable(o_saddr[s*20 +: 20])
			&& $stable(o_sdata[s*32 +: 32]) && $stable(o_ssel[s*4 +: 4]) && $stable(o_swe[s]))
		else
		begin
			errors++;
			$display("Mismatch o_saddr[%0d]: %h changed while stalled", s, o_saddr[s*20 +: 20]);
		end

		// address bit 15 tags the master, which must still hold cyc
		owner_only: assert property (@(posedge i_clk) disable iff (!i_rst_n)
			o_sstb[s] |-> o_scyc[s] && (o_saddr[s*20+16 +: 4] == 4'(s))
			&& mcyc[o_saddr[s*20+15]])
		else
		begin
			errors++;
			$display("Mismatch o_saddr[%0d]: %h strobed outside its owner", s, o_saddr[s*20 +: 20]);
		end
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	//////////////////////////////////////////////////
	// stimulus helpers
	//////////////////////////////////////////////////

	// writes get fresh addresses, reads go back over the last ones
	task automatic fill_burst(input int m, input int s, input logic we);
		logic [31:0] r;
		logic [19:0] a;
		q_we[m] = we;
		for (int k = 0; k < BURST; k++)
		begin
			if (we)
			begin
				r = lcg_next();
				a = {4'(s), 1'(m), r[14:2], 2'b00};
				q_addr[m][k] = a;
				q_data[m][k] = lcg_next();
				q_sel[m][k]  = r[19:16];
				if (!ref_val.exists(a))
				begin
					ref_val[a] = 4'h0;
					ref_mem[a] = '0;
				end
				for (int b = 0; b < 4; b++)
				begin
					if (r[16+b])
					begin
						ref_mem[a][b*8 +: 8] = q_data[m][k][b*8 +: 8];
						ref_val[a][b] = 1'b1;
					end
				end
			end
			else
				q_sel[m][k] = 4'hf;
		end
	endtask

	task automatic drive_req(input int m, input int k);
		mstb[m]          <= 1'b1;
		mwe[m]           <= q_we[m];
		maddr[m*20 +: 20] <= q_addr[m][k];
		mdata[m*32 +: 32] <= q_data[m][k];
		msel[m*4 +: 4]   <= q_sel[m][k];
	endtask

	// pipelined burst that ends when every accepted beat is acked or on err
	task automatic run_burst(input int m, input int n);
		int cyc_n;
		cyc_n = 0;
		n_acc[m] = 0;
		n_ack[m] = 0;
		n_err[m] = 0;
		t_acc[m] = -1;
		t_err[m] = -1;
		@(posedge i_clk);
		mcyc[m] <= 1'b1;
		drive_req(m, 0);
		forever
		begin
			@(posedge i_clk);
			cyc_n++;
			if (o_mack[m])
			begin
				rd_data[m][n_ack[m]] = o_mdata[m*32 +: 32];
				n_ack[m]++;
			end
			if (o_merr[m])
			begin
				n_err[m]++;
				t_err[m] = cyc_n;
				assert (o_sstb == 2'b00)
				else
				begin
					errors++;
					$display("Mismatch o_sstb: %h during o_merr, expected 0", o_sstb);
				end
				break;
			end
			if (mstb[m] && !o_mstall[m])
			begin
				if (t_acc[m] < 0)
					t_acc[m] = cyc_n;
				n_acc[m]++;
				if (n_acc[m] < n)
					drive_req(m, n_acc[m]);
				else
					mstb[m] <= 1'b0;
			end
			if ((n_acc[m] == n) && (n_ack[m] == n))
				break;
		end
		mcyc[m] <= 1'b0;
		mstb[m] <= 1'b0;
		@(posedge i_clk);
	endtask

	task automatic check_counts(input int m, input int n);
		assert ((n_acc[m] == n) && (n_ack[m] == n) && (n_err[m] == 0))
		else
		begin
			errors++;
			$display("Mismatch o_mack[%0d] count: %h accepts %h acks %h errs, expected %h",
				m, n_acc[m], n_ack[m], n_err[m], n);
		end
	endtask

	task automatic check_read(input int m);
		logic [19:0] a;
		for (int k = 0; k < BURST; k++)
		begin
			a = q_addr[m][k];
			for (int b = 0; b < 4; b++)
			begin
				if (ref_val[a][b])
					assert (rd_data[m][k][b*8 +: 8] == ref_mem[a][b*8 +: 8])
					else
					begin
						errors++;
						$display("Mismatch o_mdata[%0d] at %h: %h expected byte %0d = %h",
							m, a, rd_data[m][k], b, ref_mem[a][b*8 +: 8]);
					end
			end
		end
	endtask

	task automatic write_read_all();
		for (int m = 0; m < 2; m++)
		begin
			for (int s = 0; s < 2; s++)
			begin
				fill_burst(m, s, 1'b1);
				run_burst(m, BURST);
				check_counts(m, BURST);
				fill_burst(m, s, 1'b0);
				run_burst(m, BURST);
				check_counts(m, BURST);
				check_read(m);
			end
		end
	endtask

	task automatic end_test(input string name);
		tests++;
		$display("test %s %s, %0d errors", name,
			(errors == err_mark) ? "ok" : "failing", errors - err_mark);
		err_mark = errors;
	endtask

	//////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////

	initial
	begin
		i_rst_n  = 1'b0;
		mcyc     = '0;
		mstb     = '0;
		mwe      = '0;
		maddr    = '0;
		mdata    = '0;
		msel     = '0;
		stall_en = '0;
		mute     = '0;
		repeat (5) @(posedge i_clk);
		i_rst_n <= 1'b1;

		// quiet bus until the first request
		repeat (6)
		begin
			@(posedge i_clk);
			assert ((o_scyc | o_sstb | o_mack | o_merr) == 2'b00)
			else
			begin
				errors++;
				$display("Mismatch o_scyc/o_sstb/o_mack/o_merr: %h %h %h %h after reset",
					o_scyc, o_sstb, o_mack, o_merr);
			end
		end
		end_test("reset");

		write_read_all();
		end_test("write_read");

		// both masters start on the same edge at the same slave and master 0 must win
		fill_burst(0, 0, 1'b1);
		fill_burst(1, 0, 1'b1);
		fork
			run_burst(0, BURST);
			run_burst(1, BURST);
		join
		check_counts(0, BURST);
		check_counts(1, BURST);
		assert (t_acc[0] < t_acc[1])
		else
		begin
			errors++;
			$display("master 1 got the slave before master 0 in contention");
		end
		end_test("contention");

		stall_en <= 2'b11;
		write_read_all();
		stall_en <= 2'b00;
		end_test("back_pressure");

		for (int m = 0; m < 2; m++)
		begin
			q_we[m]      = 1'b0;
			q_sel[m][0]  = 4'hf;
			q_addr[m][0] = {4'(32'd2 + lcg_next() % 14), 16'h0040};
			run_burst(m, 1);
			assert ((n_err[m] == 1) && (n_acc[m] == 0) && (n_ack[m] == 0))
			else
			begin
				errors++;
				$display("Mismatch o_merr[%0d]: %h errs for %h, expected 1", m, n_err[m],
					q_addr[m][0]);
			end
		end
		end_test("unmapped");

		// single read of slave 1 that the muted slave never answers
		mute <= 2'b10;
		q_we[0]      = 1'b0;
		q_sel[0][0]  = 4'hf;
		q_addr[0][0] = 20'h1_0040;
		run_burst(0, 1);
		mute <= 2'b00;
		assert ((n_err[0] == 1) && (n_acc[0] == 1) && (n_ack[0] == 0)
			&& (t_err[0] - t_acc[0] >= wbx_pkg::TIMEOUT_CYCLES)
			&& (t_err[0] - t_acc[0] <= wbx_pkg::TIMEOUT_CYCLES + 4))
		else
		begin
			errors++;
			$display("Mismatch o_merr[0] delay: %h cycles, %h errs", t_err[0] - t_acc[0],
				n_err[0]);
		end
		end_test("ack_timeout");

		$display("tests run: %0d, errors: %0d", tests, errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

	// twice the summed budgets of all tests
	initial
	begin
		repeat (2 * RUN_CYC) @(posedge i_clk);
		$display("watchdog expired, the run did not finish in time");
		$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire
